/* common/ucode_pkg.sv */
package ucode_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes and timing
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W = 8;
    localparam int DATA_W = 8;

    // Every micro-state is held this many clock cycles
    localparam int STEP_CYCLES = 21;
    localparam int STEP_CNT_W  = 5;

    // Program image starts here in the block RAM
    localparam logic [ADDR_W-1:0] PROG_BASE = 8'h05;

    ////////////////////////////////////////////////////////////
    // Instruction opcodes
    ////////////////////////////////////////////////////////////

    typedef enum logic [DATA_W-1:0] {
        STORE  = 8'd1,
        LOAD   = 8'd2,
        ADD    = 8'd3,
        SUB    = 8'd4,
        JMPGEZ = 8'd5,
        JMP    = 8'd6,
        HALT   = 8'd7
    } opcode_e;

    ////////////////////////////////////////////////////////////
    // Micro-states
    ////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        FETCH_0 = 5'd0,
        FETCH_1,
        FETCH_2,
        LOAD_0,
        LOAD_1,
        LOAD_2,
        STORE_0,
        STORE_1,
        ADD_0,
        ADD_1,
        ADD_2,
        SUB_0,
        SUB_1,
        SUB_2,
        JMPGEZ_0,
        JMP_0,
        HALT_0,
        // Shared end of every non-halt instruction
        TAIL_A,
        TAIL_B,
        HALTED
    } ustate_e;

    ////////////////////////////////////////////////////////////
    // Control word
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [4:0] alu_hi;
        logic [4:0] alu_lo;
        logic [4:0] reg_load;
        logic [4:0] bus_src;
        logic [4:0] seq_ctl;
    } ctrl_word_t;

    // Field order: alu_hi, alu_lo, reg_load, bus_src, seq_ctl
    localparam ctrl_word_t CW_IDLE       = '{5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00000};
    localparam ctrl_word_t CW_NEXT       = '{5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00001};
    localparam ctrl_word_t CW_MEM_READ   = '{5'b00000, 5'b00000, 5'b00000, 5'b00100, 5'b00001};
    localparam ctrl_word_t CW_FETCH_IR   = '{5'b00000, 5'b00000, 5'b00011, 5'b00000, 5'b10001};
    localparam ctrl_word_t CW_DECODE     = '{5'b00000, 5'b00000, 5'b00000, 5'b00100, 5'b00010};
    localparam ctrl_word_t CW_LOAD_ACC   = '{5'b00000, 5'b00000, 5'b01100, 5'b00000, 5'b00001};
    localparam ctrl_word_t CW_ACC_WRITE  = '{5'b00000, 5'b00000, 5'b10000, 5'b00000, 5'b00001};
    localparam ctrl_word_t CW_STORE_ADDR = '{5'b00000, 5'b00000, 5'b00000, 5'b10000, 5'b00001};
    localparam ctrl_word_t CW_STORE_DATA = '{5'b00000, 5'b00000, 5'b00000, 5'b01000, 5'b00001};
    localparam ctrl_word_t CW_ALU_OPND   = '{5'b00000, 5'b00000, 5'b00100, 5'b00000, 5'b00001};
    localparam ctrl_word_t CW_SUB_RESULT = '{5'b00000, 5'b00001, 5'b00000, 5'b00000, 5'b00001};
    localparam ctrl_word_t CW_JUMP       = '{5'b00000, 5'b00000, 5'b00000, 5'b00001, 5'b00001};
    localparam ctrl_word_t CW_HALT       = '{5'b00000, 5'b00010, 5'b00000, 5'b00000, 5'b00000};
    localparam ctrl_word_t CW_TAIL_A     = '{5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b01001};
    localparam ctrl_word_t CW_TAIL_B     = '{5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00100};

endpackage

/* common/seq_if.sv */
`timescale 1ns/1ps

interface seq_if;

    // Last cycle of the current dwell
    logic step_done;

    // First micro-state of the decoded instruction
    ucode_pkg::ustate_e entry_state;
    logic               entry_valid;

    ucode_pkg::ustate_e upc;
    logic               halted;

    modport timer (
        input  halted,
        output step_done
    );

    modport dispatch (
        output entry_state,
        output entry_valid
    );

    modport sequencer (
        input  step_done,
        input  entry_state,
        input  entry_valid,
        output upc,
        output halted
    );

    modport store (
        input  upc
    );

endinterface

/* sequencer/step_timer.sv */
`timescale 1ns/1ps

module step_timer
    import ucode_pkg::*;
(
    input  logic clk,
    input  logic reset,
    seq_if.timer seq
);

    logic [STEP_CNT_W-1:0] dwell_cnt;
    logic                  last_cycle;

    assign last_cycle = (dwell_cnt == STEP_CNT_W'(STEP_CYCLES - 1));

    // No more steps once the CPU has halted
    assign seq.step_done = last_cycle && !seq.halted;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dwell_cnt <= '0;
        end
        else if (seq.halted)
        begin
            dwell_cnt <= dwell_cnt;
        end
        else if (last_cycle)
        begin
            dwell_cnt <= '0;
        end
        else
        begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

endmodule

/* sequencer/opcode_dispatch.sv */
`timescale 1ns/1ps

module opcode_dispatch
    import ucode_pkg::*;
(
    input  logic [DATA_W-1:0] ir,
    seq_if.dispatch           seq
);

    always_comb
    begin
        seq.entry_valid = 1'b1;
        case (opcode_e'(ir))
            LOAD:
                seq.entry_state = LOAD_0;
            STORE:
                seq.entry_state = STORE_0;
            ADD:
                seq.entry_state = ADD_0;
            SUB:
                seq.entry_state = SUB_0;
            JMPGEZ:
                seq.entry_state = JMPGEZ_0;
            JMP:
                seq.entry_state = JMP_0;
            HALT:
                seq.entry_state = HALT_0;
            default:
            begin
                // No entry for an unknown opcode
                seq.entry_state = FETCH_0;
                seq.entry_valid = 1'b0;
            end
        endcase
    end

endmodule

/* sequencer/micro_sequencer.sv */
`timescale 1ns/1ps

module micro_sequencer
    import ucode_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    seq_if.sequencer  seq
);

    ustate_e state;
    ustate_e state_next;

    ////////////////////////////////////////////////////////////
    // Successor chain
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (state)
            FETCH_0:  state_next = FETCH_1;
            FETCH_1:  state_next = FETCH_2;
            FETCH_2:  state_next = seq.entry_valid ? seq.entry_state : TAIL_B;

            LOAD_0:   state_next = LOAD_1;
            LOAD_1:   state_next = LOAD_2;
            LOAD_2:   state_next = TAIL_A;

            STORE_0:  state_next = STORE_1;
            STORE_1:  state_next = TAIL_A;

            ADD_0:    state_next = ADD_1;
            ADD_1:    state_next = ADD_2;
            ADD_2:    state_next = TAIL_A;

            SUB_0:    state_next = SUB_1;
            SUB_1:    state_next = SUB_2;
            SUB_2:    state_next = TAIL_A;

            // Jumps already moved pc, only the fetch return is left
            JMPGEZ_0: state_next = TAIL_B;
            JMP_0:    state_next = TAIL_B;

            TAIL_A:   state_next = TAIL_B;
            TAIL_B:   state_next = FETCH_0;

            HALT_0:   state_next = HALTED;
            HALTED:   state_next = HALTED;

            default:  state_next = FETCH_0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Micro-state register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= FETCH_0;
        end
        else if (seq.step_done)
        begin
            state <= state_next;
        end
    end

    assign seq.upc    = state;
    assign seq.halted = (state == HALTED);

endmodule

/* src/control_store.sv */
`timescale 1ns/1ps

module control_store
    import ucode_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    seq_if.store              seq,
    input  logic              flag,
    input  logic [ADDR_W-1:0] mar,
    input  logic [ADDR_W-1:0] pc,
    output ctrl_word_t        control,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              mem_rd_en,
    output logic              mem_wr_en
);

    ctrl_word_t        word_next;
    logic [ADDR_W-1:0] addr_next;
    logic              rd_next;
    logic              wr_next;

    ////////////////////////////////////////////////////////////
    // Microcode table
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        word_next = CW_IDLE;
        addr_next = '0;
        rd_next   = 1'b0;
        wr_next   = 1'b0;
        case (seq.upc)
            FETCH_0:
            begin
                word_next = CW_MEM_READ;
                addr_next = pc + PROG_BASE;
                rd_next   = 1'b1;
            end
            FETCH_1:  word_next = CW_FETCH_IR;
            FETCH_2:  word_next = CW_DECODE;

            // Operand read for the memory instructions
            LOAD_0, ADD_0, SUB_0:
            begin
                word_next = CW_MEM_READ;
                addr_next = mar;
                rd_next   = 1'b1;
            end
            LOAD_1:   word_next = CW_LOAD_ACC;
            LOAD_2, ADD_2:
                      word_next = CW_ACC_WRITE;
            ADD_1, SUB_1:
                      word_next = CW_ALU_OPND;
            SUB_2:    word_next = CW_SUB_RESULT;

            STORE_0:  word_next = CW_STORE_ADDR;
            STORE_1:
            begin
                word_next = CW_STORE_DATA;
                addr_next = mar;
                wr_next   = 1'b1;
            end

            // Branch taken on flag low
            JMPGEZ_0: word_next = flag ? CW_NEXT : CW_JUMP;
            JMP_0:    word_next = CW_JUMP;
            HALT_0:   word_next = CW_HALT;

            TAIL_A:   word_next = CW_TAIL_A;
            TAIL_B:   word_next = CW_TAIL_B;
            default:  word_next = CW_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            control   <= CW_IDLE;
            mem_addr  <= '0;
            mem_rd_en <= 1'b0;
            mem_wr_en <= 1'b0;
        end
        else
        begin
            control   <= word_next;
            mem_addr  <= addr_next;
            mem_rd_en <= rd_next;
            mem_wr_en <= wr_next;
        end
    end

endmodule

/* src/control_unit.sv */
`timescale 1ns/1ps

module control_unit
    import ucode_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] ir,
    input  logic [ADDR_W-1:0] mar,
    input  logic [ADDR_W-1:0] pc,
    input  logic              flag,
    output logic [24:0]       control,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              mem_rd_en,
    output logic              mem_wr_en
);

    seq_if seq ();

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    step_timer step_timer_i (
        .clk   (clk),
        .reset (reset),
        .seq   (seq.timer)
    );

    // Decode runs beside the timer, the result is taken in FETCH_2
    opcode_dispatch opcode_dispatch_i (
        .ir  (ir),
        .seq (seq.dispatch)
    );

    micro_sequencer micro_sequencer_i (
        .clk   (clk),
        .reset (reset),
        .seq   (seq.sequencer)
    );

    ////////////////////////////////////////////////////////////
    // Control store
    ////////////////////////////////////////////////////////////

    control_store control_store_i (
        .clk       (clk),
        .reset     (reset),
        .seq       (seq.store),
        .flag      (flag),
        .mar       (mar),
        .pc        (pc),
        .control   (control),
        .mem_addr  (mem_addr),
        .mem_rd_en (mem_rd_en),
        .mem_wr_en (mem_wr_en)
    );

endmodule

/* dv/control_unit_assert.sv */
`timescale 1ns/1ps

module control_unit_assert (
    input logic        clk,
    input logic        reset,
    input logic [24:0] control,
    input logic [7:0]  mem_addr,
    input logic        mem_rd_en,
    input logic        mem_wr_en
);

    localparam logic [24:0] HALT_WORD = 25'h10000;

    logic halt_word_seen;
    logic halt_over;

    // Set for good once the HALT word has come and gone
    always @(posedge clk)
    begin
        if (reset)
        begin
            halt_word_seen <= 1'b0;
            halt_over      <= 1'b0;
        end
        else
        begin
            if (control == HALT_WORD)
                halt_word_seen <= 1'b1;
            if (halt_word_seen && control != HALT_WORD)
                halt_over <= 1'b1;
        end
    end

    enables_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd_en && mem_wr_en))
        else $error("mem_rd_en and mem_wr_en high together");

    reset_clears: assert property (@(posedge clk)
        reset |=> (control == '0 && !mem_rd_en && !mem_wr_en))
        else $error("outputs not cleared after reset");

    idle_address: assert property (@(posedge clk) disable iff (reset)
        (!mem_rd_en && !mem_wr_en) |-> mem_addr == '0)
        else $error("mem_addr driven outside a memory step");

    halted_quiet: assert property (@(posedge clk) disable iff (reset)
        halt_over |-> (control == '0 && !mem_rd_en && !mem_wr_en))
        else $error("activity after halt");

endmodule

bind control_unit control_unit_assert control_unit_assert_i (
    .clk       (clk),
    .reset     (reset),
    .control   (control),
    .mem_addr  (mem_addr),
    .mem_rd_en (mem_rd_en),
    .mem_wr_en (mem_wr_en)
);

/* dv/control_unit_checker.sv */
`timescale 1ns/1ps

module control_unit_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic [24:0] control,
    input  logic [7:0]  mem_addr,
    input  logic        mem_rd_en,
    input  logic        mem_wr_en,
    input  logic        exp_valid,
    input  logic [24:0] exp_control,
    input  logic [7:0]  exp_addr,
    input  logic        exp_rd,
    input  logic        exp_wr,
    input  logic        row_last,
    input  int          row_num,
    input  int          step_num,
    input  logic [7:0]  row_op,
    input  logic        done,
    output int          error_count,
    output int          rows_checked
);

    int   phase = 0;
    int   errors = 0;
    int   rows = 0;
    int   rows_failed = 0;
    int   row_errors = 0;
    int   steps = 0;
    logic reset_seen = 1'b0;
    logic reported = 1'b0;

    assign error_count  = errors;
    assign rows_checked = rows;

    // Phase 1 is the first cycle of an output step
    always @(posedge clk)
    begin
        reset_seen <= reset;
        if (reset)
            phase <= 0;
        else if (phase == 20)
            phase <= 0;
        else
            phase <= phase + 1;
    end

    always @(negedge clk)
    begin
        if (reset && reset_seen && (control !== '0 || mem_rd_en !== 1'b0 || mem_wr_en !== 1'b0))
        begin
            $display("FAILED %0t: outputs not cleared during reset", $time);
            errors = errors + 1;
        end

        // Middle of the step
        if (!reset && exp_valid && phase == 11)
        begin
            steps = steps + 1;
            if (control !== exp_control || mem_addr !== exp_addr ||
                mem_rd_en !== exp_rd || mem_wr_en !== exp_wr)
            begin
                $display("FAILED %0t: row %0d step %0d got %h %h rd=%b wr=%b, expected %h %h rd=%b wr=%b",
                         $time, row_num, step_num, control, mem_addr, mem_rd_en, mem_wr_en,
                         exp_control, exp_addr, exp_rd, exp_wr);
                errors     = errors + 1;
                row_errors = row_errors + 1;
            end
            if (row_last)
            begin
                if (row_errors == 0)
                    $display("Row %0d op %h: %0d steps ok", row_num, row_op, step_num + 1);
                else
                    $display("Row %0d op %h: %0d of %0d steps wrong", row_num, row_op,
                             row_errors, step_num + 1);
                if (row_errors != 0)
                    rows_failed = rows_failed + 1;
                rows       = rows + 1;
                row_errors = 0;
            end
        end

        if (done && !reported)
        begin
            reported = 1'b1;
            $display("Rows %0d, rows failed %0d, steps %0d, errors %0d",
                     rows, rows_failed, steps, errors);
        end
    end

endmodule

/* dv/tb_control_unit.sv */
`timescale 1ns/1ps

module tb_control_unit
    import ucode_pkg::*;
();

    localparam int          HALF_PERIOD  = 20;
    localparam int          DWELL        = 21;
    localparam int          MAX_ROWS     = 9;
    localparam int          MAX_STEPS    = 8;
    localparam logic [7:0]  FETCH_OFFSET = 8'h05;

    logic        clk;
    logic        reset;
    logic [7:0]  ir;
    logic [7:0]  mar;
    logic [7:0]  pc;
    logic        flag;
    logic [24:0] control;
    logic [7:0]  mem_addr;
    logic        mem_rd_en;
    logic        mem_wr_en;

    // Expected step handed to the checker
    logic        exp_valid = 1'b0;
    logic [24:0] exp_control = '0;
    logic [7:0]  exp_addr = '0;
    logic        exp_rd = 1'b0;
    logic        exp_wr = 1'b0;
    logic        row_last = 1'b0;
    int          row_num = 0;
    int          step_num = 0;
    logic        done = 1'b0;
    int          error_count;
    int          rows_checked;

    ////////////////////////////////////////////////////////////
    // Instruction table
    ////////////////////////////////////////////////////////////

    int          n_rows = 0;
    int          total_steps = 0;
    logic [7:0]  tab_op   [MAX_ROWS];
    logic [7:0]  tab_mar  [MAX_ROWS];
    logic [7:0]  tab_pc   [MAX_ROWS];
    logic        tab_flag [MAX_ROWS];
    int          tab_len  [MAX_ROWS];
    logic [24:0] tab_word [MAX_ROWS][MAX_STEPS];
    logic [7:0]  tab_addr [MAX_ROWS][MAX_STEPS];
    logic        tab_rd   [MAX_ROWS][MAX_STEPS];
    logic        tab_wr   [MAX_ROWS][MAX_STEPS];
    integer      seed = 32'hdb2e_b497;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    control_unit control_unit_i (
        .clk       (clk),
        .reset     (reset),
        .ir        (ir),
        .mar       (mar),
        .pc        (pc),
        .flag      (flag),
        .control   (control),
        .mem_addr  (mem_addr),
        .mem_rd_en (mem_rd_en),
        .mem_wr_en (mem_wr_en)
    );

    control_unit_checker monitor_i (
        .clk          (clk),
        .reset        (reset),
        .control      (control),
        .mem_addr     (mem_addr),
        .mem_rd_en    (mem_rd_en),
        .mem_wr_en    (mem_wr_en),
        .exp_valid    (exp_valid),
        .exp_control  (exp_control),
        .exp_addr     (exp_addr),
        .exp_rd       (exp_rd),
        .exp_wr       (exp_wr),
        .row_last     (row_last),
        .row_num      (row_num),
        .step_num     (step_num),
        .row_op       (ir),
        .done         (done),
        .error_count  (error_count),
        .rows_checked (rows_checked)
    );

    task automatic put_step(input int r, input int s, input logic [24:0] w,
                            input logic [7:0] a, input logic rd, input logic wr);
        tab_word[r][s] = w;
        tab_addr[r][s] = a;
        tab_rd[r][s]   = rd;
        tab_wr[r][s]   = wr;
    endtask

    // Body and tail words follow the three fetch steps, rd_at and wr_at index the body
    task automatic add_row(input logic [7:0] op, input logic fl, input int rd_at,
                           input int wr_at, input int n_body, input logic [24:0] w0,
                           input logic [24:0] w1, input logic [24:0] w2,
                           input logic [24:0] w3, input logic [24:0] w4);
        logic [24:0] body [5];
        logic        mem_step;
        int          r;
        int          s;
        r             = n_rows;
        body[0]       = w0;
        body[1]       = w1;
        body[2]       = w2;
        body[3]       = w3;
        body[4]       = w4;
        tab_op[r]     = op;
        tab_flag[r]   = fl;
        tab_mar[r]    = 8'($random(seed));
        tab_pc[r]     = 8'($random(seed));
        tab_len[r]    = 3 + n_body;
        put_step(r, 0, 25'h81, tab_pc[r] + FETCH_OFFSET, 1'b1, 1'b0);
        put_step(r, 1, 25'hc11, 8'h00, 1'b0, 1'b0);
        put_step(r, 2, 25'h82, 8'h00, 1'b0, 1'b0);
        for (s = 0; s < n_body; s++)
        begin
            mem_step = (s == rd_at) || (s == wr_at);
            put_step(r, 3 + s, body[s], mem_step ? tab_mar[r] : 8'h00, s == rd_at, s == wr_at);
        end
        n_rows      = n_rows + 1;
        total_steps = total_steps + tab_len[r];
    endtask

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (reset === 1'b0)
            cycle_cnt <= cycle_cnt + 1;
    end

    initial
    begin
        wait (cycle_limit > 0);
        wait (cycle_cnt >= cycle_limit);
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial
    begin
        int r;
        int s;
        reset = 1'b1;
        ir    = 8'h00;
        mar   = 8'h00;
        pc    = 8'h00;
        flag  = 1'b0;

        add_row(LOAD,   1'b0,  0, -1, 5, 25'h81,  25'h3001, 25'h4001, 25'h09, 25'h04);
        add_row(STORE,  1'b0, -1,  1, 4, 25'h201, 25'h101,  25'h09,   25'h04, 25'h0);
        add_row(ADD,    1'b1,  0, -1, 5, 25'h81,  25'h1001, 25'h4001, 25'h09, 25'h04);
        add_row(SUB,    1'b0,  0, -1, 5, 25'h81,  25'h1001, 25'h8001, 25'h09, 25'h04);
        add_row(JMPGEZ, 1'b0, -1, -1, 2, 25'h21,  25'h04,   25'h0,    25'h0,  25'h0);
        add_row(JMPGEZ, 1'b1, -1, -1, 2, 25'h01,  25'h04,   25'h0,    25'h0,  25'h0);
        add_row(JMP,    1'b1, -1, -1, 2, 25'h21,  25'h04,   25'h0,    25'h0,  25'h0);
        // Not an opcode, goes straight to the last tail step
        add_row(8'hc3,  1'b0, -1, -1, 1, 25'h04,  25'h0,    25'h0,    25'h0,  25'h0);
        add_row(HALT,   1'b0, -1, -1, 3, 25'h10000, 25'h0,  25'h0,    25'h0,  25'h0);
        cycle_limit = total_steps * DWELL + 100;

        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        for (r = 0; r < n_rows; r++)
        begin
            ir   = tab_op[r];
            mar  = tab_mar[r];
            pc   = tab_pc[r];
            flag = tab_flag[r];
            for (s = 0; s < tab_len[r]; s++)
            begin
                // Output step starts one cycle after the micro-state
                @(posedge clk);
                #2;
                exp_valid   = 1'b1;
                row_num     = r;
                step_num    = s;
                exp_control = tab_word[r][s];
                exp_addr    = tab_addr[r][s];
                exp_rd      = tab_rd[r][s];
                exp_wr      = tab_wr[r][s];
                row_last    = (s == tab_len[r] - 1);
                repeat (DWELL - 1) @(posedge clk);
                #2;
            end
        end

        exp_valid = 1'b0;
        done      = 1'b1;
        repeat (2) @(posedge clk);
        if (error_count == 0 && rows_checked == n_rows)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* build.f */
common/ucode_pkg.sv
common/seq_if.sv
sequencer/step_timer.sv
sequencer/opcode_dispatch.sv
sequencer/micro_sequencer.sv
src/control_store.sv
src/control_unit.sv
dv/control_unit_assert.sv
dv/control_unit_checker.sv
dv/tb_control_unit.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_control_unit -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_control_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
